/* logic/crc32_eth_x32.sv */
module crc32_eth_x32 (
	input logic xgmii_rx_clk,
	input logic reset,
	input logic crc_reset,
	input logic ce,
	input logic [eth_rx_pkg::CRC_WIDTH-1:0] din,
	input eth_rx_pkg::crc_len_t din_len,
	output logic [eth_rx_pkg::CRC_WIDTH-1:0] crc_value
);
	import eth_rx_pkg::*;

	// Data half of the update, computed against a zero state
	logic [CRC_WIDTH-1:0] data_term;
	crc_len_t len_q;
	logic [CRC_WIDTH-1:0] crc_state;
	logic [CRC_WIDTH-1:0] crc_inv;

	// Reflected CRC-32 over the leading len bytes of data
	// first byte in data[31:24]
	function automatic logic [CRC_WIDTH-1:0] crc_update(
		input logic [CRC_WIDTH-1:0] crc_in,
		input logic [CRC_WIDTH-1:0] data,
		input crc_len_t len
	);
		logic [CRC_WIDTH-1:0] c;
		c = crc_in;
		for (int i = 0; i < FCS_BYTES; i++) begin
			if (i < len) begin
				c = c ^ {24'h0, data[CRC_WIDTH-1-8*i -: 8]};
				for (int k = 0; k < 8; k++) begin
					if (c[0]) begin
						c = (c >> 1) ^ CRC_POLY_REFL;
					end else begin
						c = c >> 1;
					end
				end
			end
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// Two stage update

	// The update is linear so state and data parts split cleanly
	// Stage 1 folds the data, stage 2 shifts the state and merges
	always_ff @(posedge xgmii_rx_clk) begin
		if (ce) begin
			data_term <= crc_update('0, din, din_len);
		end
	end

	always_ff @(posedge xgmii_rx_clk) begin
		if (reset || crc_reset) begin
			len_q <= '0;
			crc_state <= CRC_INIT;
		end else if (ce) begin
			len_q <= din_len;
			crc_state <= crc_update(crc_state, '0, len_q) ^ data_term;
		end
	end

	// Complemented and in the byte order the FCS arrives in
	assign crc_inv = ~crc_state;
	assign crc_value = swap_bytes(crc_inv);

endmodule

/* logic/eth_rx_pkg.sv */
package eth_rx_pkg;

	////////////////////////////////////////////////////////////
	// Frame and checksum constants

	// Bytes per output beat
	localparam int BEAT_BYTES = 4;

	// Trailing FCS length in bytes
	localparam int FCS_BYTES = 4;

	localparam int CRC_WIDTH = 32;

	// 04C11DB7 in bit-reversed form for the LSB-first shift
	localparam logic [CRC_WIDTH-1:0] CRC_POLY_REFL = 32'hedb8_8320;
	localparam logic [CRC_WIDTH-1:0] CRC_INIT = 32'hffff_ffff;

	////////////////////////////////////////////////////////////
	// Types

	// Receive FSM
	typedef enum logic [1:0] {
		RX_IDLE = 2'd0,
		RX_PREAMBLE = 2'd1,
		RX_BODY = 2'd2
	} rx_state_t;

	// Number of bytes handed to the CRC in one word, 0 to 4
	typedef logic [2:0] crc_len_t;

	// Output stream beat
	typedef struct packed {
		logic [8*BEAT_BYTES-1:0] data;	// first byte in data[7:0]
		logic [BEAT_BYTES-1:0] strb;
		logic valid;
		logic last;
		logic error;	// Qualified by last
	} rx_stream_t;

	// Swap between wire order (first byte high) and stream order (first byte low)
	function automatic logic [CRC_WIDTH-1:0] swap_bytes(input logic [CRC_WIDTH-1:0] word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

endpackage

/* logic/rx_fcs_check.sv */
module rx_fcs_check (
	input logic xgmii_rx_clk,
	input logic reset,
	input logic valid,
	input logic fcs_due,
	input logic abort,
	input logic [eth_rx_pkg::CRC_WIDTH-1:0] expected_fcs,
	input logic [eth_rx_pkg::CRC_WIDTH-1:0] crc_value,
	output logic last,
	output logic error
);
	import eth_rx_pkg::*;

	////////////////////////////////////////////////////////////
	// Expected FCS delay line

	// Two valid words to match the CRC pipeline
	logic [CRC_WIDTH-1:0] fcs_d1;
	logic [CRC_WIDTH-1:0] fcs_d2;

	always_ff @(posedge xgmii_rx_clk) begin
		if (valid) begin
			fcs_d1 <= expected_fcs;
			fcs_d2 <= fcs_d1;
		end
	end

	////////////////////////////////////////////////////////////
	// End of frame flags

	// Flags are single-cycle strobes
	always_ff @(posedge xgmii_rx_clk) begin
		if (reset) begin
			last <= 1'b0;
			error <= 1'b0;
		end else begin
			last <= 1'b0;
			error <= 1'b0;

			if (valid) begin
				if (abort) begin
					// In-band error ends the frame at once
					last <= 1'b1;
					error <= 1'b1;
				end else if (fcs_due) begin
					// CRC now covers the whole body
					last <= 1'b1;
					error <= (fcs_d2 != crc_value);
				end
			end
		end
	end

endmodule

/* logic/rx_frame_control.sv */
module rx_frame_control (
	input logic xgmii_rx_clk,
	input logic reset,
	input logic valid,
	input logic start_seen,
	input logic preamble_ok,
	input xgmii_pkg::lane_flags_t end_lanes,
	input xgmii_pkg::lane_flags_t error_lanes,
	output logic in_body,
	output logic first_body,
	output logic crc_reset,
	output logic fcs_due,
	output logic abort
);
	import eth_rx_pkg::*;

	rx_state_t state;

	// First stage of the FCS-pending pipeline
	logic end_pending;

	assign in_body = (state == RX_BODY);

	// In-band error anywhere inside a frame kills it
	// Errors between frames are ignored
	assign abort = valid && (|error_lanes) && (state != RX_IDLE);

	////////////////////////////////////////////////////////////
	// Receive FSM

	always_ff @(posedge xgmii_rx_clk) begin
		if (reset) begin
			state <= RX_IDLE;
			first_body <= 1'b0;
			crc_reset <= 1'b0;
			end_pending <= 1'b0;
			fcs_due <= 1'b0;
		end else if (valid) begin
			// Marks the word right after the preamble
			first_body <= (state == RX_PREAMBLE);
			// High through the preamble word so the CRC starts from its seed
			crc_reset <= (state == RX_IDLE) && start_seen;

			// End marker walks two stages to line up with the CRC latency
			end_pending <= 1'b0;
			fcs_due <= end_pending;

			case (state)
				RX_IDLE: begin
					// Idles and stray errors are dropped here
					if (start_seen) begin
						state <= RX_PREAMBLE;
					end
				end

				RX_PREAMBLE: begin
					// Exactly one preamble word is allowed
					// Anything else drops the frame
					if (preamble_ok) begin
						state <= RX_BODY;
					end else begin
						state <= RX_IDLE;
					end
				end

				RX_BODY: begin
					// End can sit in any lane
					if (|end_lanes) begin
						end_pending <= 1'b1;
						state <= RX_IDLE;
					end
				end

				default: begin
					state <= RX_IDLE;
				end
			endcase

			// Abort wins over everything above
			if (abort) begin
				state <= RX_IDLE;
				end_pending <= 1'b0;
				fcs_due <= 1'b0;
			end
		end
	end

endmodule

/* logic/rx_lane_packer.sv */
module rx_lane_packer (
	input logic xgmii_rx_clk,
	input logic reset,
	input xgmii_pkg::xgmii_bus_t xgmii_rx,
	input xgmii_pkg::lane_flags_t end_lanes,
	input logic in_body,
	input logic first_body,
	output eth_rx_pkg::rx_stream_t beat,
	output logic [eth_rx_pkg::CRC_WIDTH-1:0] crc_data,
	output eth_rx_pkg::crc_len_t crc_len,
	output logic [eth_rx_pkg::CRC_WIDTH-1:0] expected_fcs
);
	import xgmii_pkg::*;
	import eth_rx_pkg::*;

	// Previous word in stream order, held until we know it is not FCS
	logic [8*BEAT_BYTES-1:0] held;
	logic [BEAT_BYTES-1:0] strb_next;

	logic beat_valid;
	logic [8*BEAT_BYTES-1:0] beat_data;
	logic [BEAT_BYTES-1:0] beat_strb;

	////////////////////////////////////////////////////////////
	// Decide what part of the held word is payload

	always_comb begin
		strb_next = '0;
		crc_len = '0;
		expected_fcs = '0;

		// Word after the preamble is only captured, never sent on its own cycle
		if (xgmii_rx.valid && in_body && !first_body) begin
			if (end_lanes[3]) begin
				// Held word is all FCS
				expected_fcs = swap_bytes(held);
			end else if (end_lanes[2]) begin
				strb_next = 4'b0001;
				crc_len = 3'd1;
				expected_fcs = {held[15:8], held[23:16], held[31:24], xgmii_rx.data[31:24]};
			end else if (end_lanes[1]) begin
				strb_next = 4'b0011;
				crc_len = 3'd2;
				expected_fcs = {held[23:16], held[31:24], xgmii_rx.data[31:16]};
			end else if (end_lanes[0]) begin
				strb_next = 4'b0111;
				crc_len = 3'd3;
				expected_fcs = {held[31:24], xgmii_rx.data[31:8]};
			end else if (xgmii_rx.ctl == '0) begin
				// Frame continues so the whole held word is payload
				strb_next = '1;
				crc_len = crc_len_t'(FCS_BYTES);
			end
		end
	end

	// CRC takes bytes in wire order
	assign crc_data = swap_bytes(held);

	////////////////////////////////////////////////////////////
	// Registers

	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx.valid) begin
			held <= swap_bytes(xgmii_rx.data);
		end
	end

	// Beat strobe drops on every cycle without new payload
	always_ff @(posedge xgmii_rx_clk) begin
		if (reset) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= |strb_next;
		end
	end

	always_ff @(posedge xgmii_rx_clk) begin
		if (|strb_next) begin
			beat_data <= held;
			beat_strb <= strb_next;
		end
	end

	// End and status flags are added at the top level
	assign beat = '{data: beat_data, strb: beat_strb, valid: beat_valid,
		last: 1'b0, error: 1'b0};

endmodule

/* logic/xgmii_lane_decoder.sv */
module xgmii_lane_decoder (
	input xgmii_pkg::xgmii_bus_t xgmii_rx,
	output xgmii_pkg::lane_flags_t end_lanes,
	output xgmii_pkg::lane_flags_t error_lanes,
	output logic start_seen,
	output logic preamble_ok
);
	import xgmii_pkg::*;

	////////////////////////////////////////////////////////////
	// Per-lane control character match

	// End and error may show up in any lane
	// Frames are not a multiple of four bytes long
	always_comb begin
		for (int lane = 0; lane < XGMII_LANES; lane++) begin
			end_lanes[lane] = xgmii_rx.ctl[lane] &&
				(xgmii_rx.data[8*lane +: 8] == XGMII_CTL_END);
			error_lanes[lane] = xgmii_rx.ctl[lane] &&
				(xgmii_rx.data[8*lane +: 8] == XGMII_CTL_ERROR);
		end
	end

	////////////////////////////////////////////////////////////
	// Start of frame

	// Start is only legal in the leftmost lane
	assign start_seen = xgmii_rx.ctl[XGMII_FIRST_LANE] &&
		(xgmii_rx.data[8*XGMII_FIRST_LANE +: 8] == XGMII_CTL_START);

	// Word after start must be plain data 55 55 55 D5
	// Any control bit makes it a bad preamble
	assign preamble_ok = (xgmii_rx.ctl == '0) &&
		(xgmii_rx.data == XGMII_PREAMBLE_SFD);

endmodule

/* logic/xgmii_pkg.sv */
package xgmii_pkg;

	////////////////////////////////////////////////////////////
	// Lane layout

	// Four byte lanes per 32-bit XGMII word
	localparam int XGMII_LANES = 4;

	// Lane 3 carries the byte that goes first on the wire
	localparam int XGMII_FIRST_LANE = XGMII_LANES - 1;

	////////////////////////////////////////////////////////////
	// Control characters

	// Only meaningful on a lane whose ctl bit is set
	localparam logic [7:0] XGMII_CTL_IDLE = 8'h07;
	localparam logic [7:0] XGMII_CTL_START = 8'hfb;
	localparam logic [7:0] XGMII_CTL_END = 8'hfd;
	localparam logic [7:0] XGMII_CTL_ERROR = 8'hfe;

	// Preamble tail and SFD in the word after the start word
	localparam logic [8*XGMII_LANES-1:0] XGMII_PREAMBLE_SFD = 32'h5555_55d5;

	////////////////////////////////////////////////////////////
	// Bus types

	// One flag per lane
	// Bit 3 belongs to the first byte of the word
	typedef logic [XGMII_LANES-1:0] lane_flags_t;

	// One receive word as delivered by the PHY
	typedef struct packed {
		// First byte on the wire sits in data[31:24]
		logic [8*XGMII_LANES-1:0] data;
		// Set per lane when the byte is a control character
		lane_flags_t ctl;
		// Word qualifier, gaps are allowed
		logic valid;
	} xgmii_bus_t;

endpackage

/* logic/xgmii_rx_mac.sv */
module xgmii_rx_mac (
	input logic xgmii_rx_clk,
	input logic reset,
	input xgmii_pkg::xgmii_bus_t xgmii_rx,
	output eth_rx_pkg::rx_stream_t rx_out
);
	import xgmii_pkg::*;
	import eth_rx_pkg::*;

	lane_flags_t end_lanes;
	lane_flags_t error_lanes;
	logic start_seen;
	logic preamble_ok;

	logic in_body;
	logic first_body;
	logic crc_reset;
	logic fcs_due;
	logic abort;

	rx_stream_t beat;
	logic [CRC_WIDTH-1:0] crc_data;
	crc_len_t crc_len;
	logic [CRC_WIDTH-1:0] expected_fcs;
	logic [CRC_WIDTH-1:0] crc_value;

	logic fcs_last;
	logic fcs_error;

	////////////////////////////////////////////////////////////
	// Datapath

	xgmii_lane_decoder u_lane_decoder (
		.xgmii_rx(xgmii_rx),
		.end_lanes(end_lanes),
		.error_lanes(error_lanes),
		.start_seen(start_seen),
		.preamble_ok(preamble_ok)
	);

	rx_frame_control u_frame_control (
		.xgmii_rx_clk(xgmii_rx_clk),
		.reset(reset),
		.valid(xgmii_rx.valid),
		.start_seen(start_seen),
		.preamble_ok(preamble_ok),
		.end_lanes(end_lanes),
		.error_lanes(error_lanes),
		.in_body(in_body),
		.first_body(first_body),
		.crc_reset(crc_reset),
		.fcs_due(fcs_due),
		.abort(abort)
	);

	rx_lane_packer u_lane_packer (
		.xgmii_rx_clk(xgmii_rx_clk),
		.reset(reset),
		.xgmii_rx(xgmii_rx),
		.end_lanes(end_lanes),
		.in_body(in_body),
		.first_body(first_body),
		.beat(beat),
		.crc_data(crc_data),
		.crc_len(crc_len),
		.expected_fcs(expected_fcs)
	);

	// CRC advances with the input words
	crc32_eth_x32 u_crc (
		.xgmii_rx_clk(xgmii_rx_clk),
		.reset(reset),
		.crc_reset(crc_reset),
		.ce(xgmii_rx.valid),
		.din(crc_data),
		.din_len(crc_len),
		.crc_value(crc_value)
	);

	rx_fcs_check u_fcs_check (
		.xgmii_rx_clk(xgmii_rx_clk),
		.reset(reset),
		.valid(xgmii_rx.valid),
		.fcs_due(fcs_due),
		.abort(abort),
		.expected_fcs(expected_fcs),
		.crc_value(crc_value),
		.last(fcs_last),
		.error(fcs_error)
	);

	////////////////////////////////////////////////////////////
	// Output merge

	// The end-of-frame beat carries no bytes
	always_comb begin
		rx_out = beat;
		rx_out.valid = beat.valid | fcs_last;
		rx_out.last = fcs_last;
		rx_out.error = fcs_error;
		if (fcs_last) begin
			rx_out.strb = '0;
		end
	end

endmodule

/* tb.f */
logic/xgmii_pkg.sv
logic/eth_rx_pkg.sv
logic/xgmii_lane_decoder.sv
logic/rx_frame_control.sv
logic/rx_lane_packer.sv
logic/crc32_eth_x32.sv
logic/rx_fcs_check.sv
logic/xgmii_rx_mac.sv
verification/tb_xgmii_rx_mac.sv

/* verification/tb_xgmii_rx_mac.sv */
module tb_xgmii_rx_mac;
	timeunit 1ns;
	timeprecision 1ps;

	import xgmii_pkg::*;
	import eth_rx_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_SEED = 24860;
	// Idle words allowed before the end-of-frame beat must have shown up
	localparam int LAST_TIMEOUT = 64;
	// Idle words watched for stray beats after a dropped frame
	localparam int QUIET_WORDS = 12;
	// Lane index of the injected error character from the first body byte
	localparam int ERROR_LANE_POS = 21;
	localparam int NUM_CASES = 13;
	localparam logic [31:0] IDLE_WORD = {4{XGMII_CTL_IDLE}};

	typedef enum logic [1:0] {
		FAULT_NONE,
		FAULT_BAD_FCS,
		FAULT_MID_ERROR,
		FAULT_BAD_PREAMBLE
	} fault_t;

	// Table row holds payload length, fault kind and random valid gaps
	typedef struct packed {
		logic [7:0] len;
		fault_t fault;
		logic gaps;
	} case_t;

	case_t case_table [NUM_CASES] = '{
		'{8'd64, FAULT_NONE, 1'b0},
		'{8'd65, FAULT_NONE, 1'b0},
		'{8'd66, FAULT_NONE, 1'b0},
		'{8'd67, FAULT_NONE, 1'b0},
		'{8'd40, FAULT_BAD_FCS, 1'b0},
		'{8'd48, FAULT_MID_ERROR, 1'b0},
		'{8'd52, FAULT_NONE, 1'b0},
		'{8'd30, FAULT_BAD_PREAMBLE, 1'b0},
		'{8'd33, FAULT_NONE, 1'b0},
		'{8'd64, FAULT_NONE, 1'b1},
		'{8'd61, FAULT_NONE, 1'b1},
		'{8'd70, FAULT_NONE, 1'b1},
		'{8'd47, FAULT_BAD_FCS, 1'b1}
	};

	logic xgmii_rx_clk;
	logic reset;
	xgmii_bus_t xgmii_rx;
	rx_stream_t rx_out;

	int error_count;
	int check_count;

	// Scoreboard state is cleared before each frame
	logic [7:0] exp_bytes [$];
	logic [7:0] got_bytes [$];
	logic frame_done;
	logic frame_error;
	logic partial_seen;

	xgmii_rx_mac u_xgmii_rx_mac (
		.xgmii_rx_clk(xgmii_rx_clk),
		.reset(reset),
		.xgmii_rx(xgmii_rx),
		.rx_out(rx_out)
	);

	initial begin
		xgmii_rx_clk = 1'b0;
		forever #(CLK_PERIOD / 2) xgmii_rx_clk = ~xgmii_rx_clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model

	// Bitwise reflected Ethernet CRC-32 that returns the value sent LSB first
	function automatic logic [31:0] ref_crc32(input logic [7:0] bytes [$]);
		logic [31:0] crc;
		crc = 32'hffff_ffff;
		foreach (bytes[i]) begin
			crc = crc ^ {24'h0, bytes[i]};
			for (int b = 0; b < 8; b++) begin
				crc = crc[0] ? ((crc >> 1) ^ 32'hedb8_8320) : (crc >> 1);
			end
		end
		return ~crc;
	endfunction

	////////////////////////////////////////////////////////////
	// Output monitor

	// Sampled on the falling edge where rx_out is settled
	always @(negedge xgmii_rx_clk) begin
		if (!reset && rx_out.valid) begin
			check_count++;
			if (rx_out.last) begin
				// End-of-frame beat carries no bytes
				assert (rx_out.strb == 4'b0000) else begin
					$display("CHECK FAILED at %0t: rx_out.strb got %b expected %b",
						$time, rx_out.strb, 4'b0000);
					error_count++;
				end
				frame_error = rx_out.error;
				frame_done = 1'b1;
			end else begin
				// Only the final data beat may be short
				assert (!partial_seen) else begin
					$display("Data beat at %0t follows a short beat in the same frame", $time);
					error_count++;
				end
				assert (rx_out.strb inside {4'b1111, 4'b0111, 4'b0011, 4'b0001}) else begin
					$display("CHECK FAILED at %0t: rx_out.strb got %b expected %s",
						$time, rx_out.strb, "packed from bit 0");
					error_count++;
				end
				for (int i = 0; i < BEAT_BYTES; i++) begin
					if (rx_out.strb[i]) begin
						got_bytes.push_back(rx_out.data[8*i +: 8]);
					end
				end
				if (rx_out.strb != 4'b1111) begin
					partial_seen = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	// Drives one valid word with a few invalid cycles before it when gaps are on
	task automatic drive_word(input logic [31:0] data, input logic [3:0] ctl, input logic gaps);
		int gap_count;
		gap_count = gaps ? $urandom_range(2) : 0;
		repeat (gap_count) begin
			@(posedge xgmii_rx_clk);
			xgmii_rx <= '{data: IDLE_WORD, ctl: 4'b1111, valid: 1'b0};
		end
		@(posedge xgmii_rx_clk);
		xgmii_rx <= '{data: data, ctl: ctl, valid: 1'b1};
	endtask

	task automatic compare_payload(input int index);
		check_count++;
		assert (got_bytes.size() == exp_bytes.size()) else begin
			$display("CHECK FAILED at %0t: case %0d rx_out byte count got %0d expected %0d",
				$time, index, got_bytes.size(), exp_bytes.size());
			error_count++;
		end
		foreach (got_bytes[i]) begin
			if (i < exp_bytes.size()) begin
				assert (got_bytes[i] == exp_bytes[i]) else begin
					$display("CHECK FAILED at %0t: case %0d rx_out.data byte %0d got %h expected %h",
						$time, index, i, got_bytes[i], exp_bytes[i]);
					error_count++;
				end
			end
		end
	endtask

	task automatic run_case(input case_t tc, input int index);
		logic [7:0] frame_bytes [$];
		// Lane stream as {ctl, byte} in wire order
		logic [8:0] lanes [$];
		logic [31:0] fcs;
		logic [31:0] word;
		logic [3:0] ctl;
		logic exp_error;
		int wait_count;

		exp_bytes.delete();
		for (int i = 0; i < tc.len; i++) begin
			exp_bytes.push_back(8'($urandom));
		end
		fcs = ref_crc32(exp_bytes);
		frame_bytes = exp_bytes;
		for (int i = 0; i < FCS_BYTES; i++) begin
			frame_bytes.push_back(fcs[8*i +: 8]);
		end
		if (tc.fault == FAULT_BAD_FCS) begin
			frame_bytes[tc.len] = frame_bytes[tc.len] ^ 8'h10;
		end

		// Body, terminate, then idle fill to a whole word
		foreach (frame_bytes[i]) begin
			lanes.push_back({1'b0, frame_bytes[i]});
		end
		lanes.push_back({1'b1, XGMII_CTL_END});
		while (lanes.size() % XGMII_LANES != 0) begin
			lanes.push_back({1'b1, XGMII_CTL_IDLE});
		end
		if (tc.fault == FAULT_MID_ERROR) begin
			lanes[ERROR_LANE_POS] = {1'b1, XGMII_CTL_ERROR};
		end

		got_bytes.delete();
		frame_done = 1'b0;
		frame_error = 1'b0;
		partial_seen = 1'b0;

		drive_word({XGMII_CTL_START, 24'h55_5555}, 4'b1000, tc.gaps);
		if (tc.fault == FAULT_BAD_PREAMBLE) begin
			drive_word(32'h5555_5555, 4'b0000, tc.gaps);
		end else begin
			drive_word(XGMII_PREAMBLE_SFD, 4'b0000, tc.gaps);
		end
		for (int w = 0; w < lanes.size() / XGMII_LANES; w++) begin
			for (int k = 0; k < XGMII_LANES; k++) begin
				word[31-8*k -: 8] = lanes[XGMII_LANES*w+k][7:0];
				ctl[3-k] = lanes[XGMII_LANES*w+k][8];
			end
			drive_word(word, ctl, tc.gaps);
		end

		if (tc.fault == FAULT_BAD_PREAMBLE) begin
			// Nothing may come out of a dropped frame
			repeat (QUIET_WORDS) drive_word(IDLE_WORD, 4'b1111, tc.gaps);
			check_count++;
			assert (got_bytes.size() == 0 && !frame_done) else begin
				$display("Case %0d produced output for a frame with a bad preamble", index);
				error_count++;
			end
		end else begin
			wait_count = 0;
			while (!frame_done && wait_count < LAST_TIMEOUT) begin
				drive_word(IDLE_WORD, 4'b1111, tc.gaps);
				wait_count++;
			end
			assert (frame_done) else begin
				$display("Case %0d timed out waiting for the end-of-frame beat", index);
				error_count++;
			end
			if (frame_done) begin
				exp_error = (tc.fault != FAULT_NONE);
				check_count++;
				assert (frame_error == exp_error) else begin
					$display("CHECK FAILED at %0t: case %0d rx_out.error got %b expected %b",
						$time, index, frame_error, exp_error);
					error_count++;
				end
				// An aborted frame delivers only part of its payload
				if (tc.fault != FAULT_MID_ERROR) begin
					compare_payload(index);
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(RANDOM_SEED));
		error_count = 0;
		check_count = 0;
		frame_done = 1'b0;
		frame_error = 1'b0;
		partial_seen = 1'b0;
		reset = 1'b1;
		xgmii_rx = '{data: IDLE_WORD, ctl: 4'b1111, valid: 1'b0};

		repeat (RESET_CYCLES) @(posedge xgmii_rx_clk);
		reset <= 1'b0;
		repeat (4) drive_word(IDLE_WORD, 4'b1111, 1'b0);

		for (int i = 0; i < NUM_CASES; i++) begin
			run_case(case_table[i], i);
		end
		repeat (4) drive_word(IDLE_WORD, 4'b1111, 1'b0);

		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
